// ==== Makefile ====
# Verilator build and run for the P-D decode unit

SRCS := $(filter-out +%,$(shell cat project.f)) rtl/p_d_params.svh

.PHONY: all run clean

all: run

obj_dir/Vtb_p_d: project.f $(SRCS)
	verilator --binary --timing -Wno-fatal --top-module tb_p_d -f project.f

run: obj_dir/Vtb_p_d
	@out="$$(./obj_dir/Vtb_p_d)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf obj_dir

// ==== project.f ====
+incdir+rtl
rtl/p_d_pkg.sv
rtl/decoder16.sv
rtl/ir.sv
rtl/op_decode.sv
rtl/arg_extract.sv
rtl/p_d.sv
test/tb_p_d.sv

// ==== rtl/arg_extract.sv ====
////////////////////////////////////////
// Register fields and arguments
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module arg_extract
	import p_d_pkg::*;
(
	input  wire ir_word_t ir,
	input  wire           short_class,	// From op_decode
	input  wire           byte_class,	// From op_decode
	output reg_id_t       reg_a,	// Bits 7..9
	output reg_id_t       reg_b,	// Bits 10..12
	output reg_id_t       reg_c,	// Bits 13..15
	output logic          d,	// Bit 6, pre-modification
	output ir_word_t      arg	// Argument word
);

	localparam int word_w = $bits(ir_word_t);

	logic [word_w-1:0] mag;	// Short magnitude, zero-extended
	logic [word_w-1:0] short_arg;	// Signed short form
	logic [word_w-1:0] byte_arg;	// Byte form

	assign reg_a = ir[7:9];
	assign reg_b = ir[10:12];
	assign reg_c = ir[13:15];
	assign d     = ir[6];

	// KA1 layout: D is the sign, bits 10..15 the magnitude
	assign mag = {{(word_w-6){1'b0}}, ir[10:15]};

	// Two's complement negate; magnitude 0 stays 0
	assign short_arg = ir[6] ? (~mag + 1'b1) : mag;

	// KA2 layout: low byte of the word
	assign byte_arg = {{(word_w-8){1'b0}}, ir[8:15]};

	always_comb begin
		if (short_class) begin
			arg = short_arg;
		end else if (byte_class) begin
			arg = byte_arg;
		end else begin
			arg = '0;	// No embedded argument
		end
	end

endmodule

`default_nettype wire

// ==== rtl/decoder16.sv ====
////////////////////////////////////////
// Enabled 4-to-16 decoder
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module decoder16
	import p_d_pkg::*;
(
	input  wire [0:1]   en,	// Both high to enable
	input  wire [0:3]   i,	// Index, bit 0 is MSB
	output logic [0:15] o	// One-hot, o[0] for index 0
);

	always_comb begin
		o = '0;
		if (&en) begin
			o[i] = 1'b1;	// Single output for the selected index
		end
	end

endmodule

`default_nettype wire

// ==== rtl/ir.sv ====
////////////////////////////////////////
// Instruction register
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module ir
	import p_d_pkg::*;
(
	input  wire           clk_sys,
	input  wire           rst_n,
	input  wire ir_word_t w,	// Internal W bus
	input  wire           strob1,	// Microstep strobe
	input  wire           w_ir,	// Bus target is IR
	output ir_word_t      ir
);

	logic load;	// Strobed write from W

	assign load = strob1 & w_ir;

	// Holds between loads, the decoders read it all cycle
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			ir <= '0;	// Decodes as illegal
		end else if (load) begin
			ir <= w;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/op_decode.sv ====
////////////////////////////////////////
// Opcode decode and class flags
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module op_decode
	import p_d_pkg::*;
(
	input  wire ir_word_t ir,
	output op_t           op,	// Mnemonic
	output logic          illegal,	// Group 00
	output logic          norm_arg,	// Groups 01 and 10
	output logic          two_word,	// Normal argument taken from the next word
	output logic          short_class,	// KA1 short argument
	output logic          byte_class,	// KA2 byte argument
	output logic          io_class	// OU or IN
);

	// Mnemonic tables, one entry per index
	localparam op_t grp01_ops [0:15] = '{
		op_lw, op_tw, op_ls, op_ri,
		op_rw, op_pw, op_rj, op_is,
		op_bb, op_bm, op_bs, op_bc,
		op_bn, op_ou, op_in, op_pufa
	};
	localparam op_t grp10_ops [0:15] = '{
		op_aw, op_ac, op_sw, op_cw,
		op_or, op_om, op_nr, op_nm,
		op_er, op_em, op_xr, op_xm,
		op_cl, op_lb, op_rb, op_cb
	};
	localparam op_t grp11_ops [0:15] = '{
		op_awt,   op_trb,   op_irb,   op_drb,
		op_cwt,   op_lwt,   op_lws,   op_rws,
		op_js,    op_ka2,   op_grp_c, op_grp_s,
		op_grp_j, op_grp_l, op_grp_g, op_brc
	};

	localparam int idx_ou = 13;	// OU position in group 01
	localparam int idx_in = 14;	// IN position in group 01
	localparam int idx_ka2 = 9;	// First non-short entry of group 11

	logic [0:15] hot_01;	// One-hot per group decoder
	logic [0:15] hot_10;
	logic [0:15] hot_11;
	logic        hit_01;	// Group decoder fired
	logic        hit_10;
	logic        hit_11;
	logic [3:0]  idx_01;	// Index recovered from one-hot
	logic [3:0]  idx_10;
	logic [3:0]  idx_11;
	logic        c_zero;	// C field is r0

	// OR of the set positions, exact for a one-hot input
	function automatic logic [3:0] hot_index(input logic [0:15] hot);
		logic [3:0] idx;
		idx = '0;
		for (int k = 0; k < 16; k++) begin
			if (hot[k]) begin
				idx = idx | 4'(k);
			end
		end
		return idx;
	endfunction

	// Group bits select the decoder, inverted where the group needs a zero
	decoder16 dec_01 (
		.en ({~ir[0],  ir[1]}),
		.i  (ir[2:5]),
		.o  (hot_01)
	);

	decoder16 dec_10 (
		.en ({ ir[0], ~ir[1]}),
		.i  (ir[2:5]),
		.o  (hot_10)
	);

	decoder16 dec_11 (
		.en ({ ir[0],  ir[1]}),
		.i  (ir[2:5]),
		.o  (hot_11)
	);

	assign hit_01 = |hot_01;
	assign hit_10 = |hot_10;
	assign hit_11 = |hot_11;

	assign idx_01 = hot_index(hot_01);
	assign idx_10 = hot_index(hot_10);
	assign idx_11 = hot_index(hot_11);

	always_comb begin
		if (hit_01) begin
			op = grp01_ops[idx_01];
		end else if (hit_10) begin
			op = grp10_ops[idx_10];
		end else if (hit_11) begin
			op = grp11_ops[idx_11];
		end else begin
			op = op_ill;	// No decoder enabled
		end
	end

	assign c_zero      = ~|ir[13:15];
	assign illegal     = ~(hit_01 | hit_10 | hit_11);
	assign norm_arg    = hit_01 | hit_10;
	assign two_word    = norm_arg & c_zero;	// C=0 means argument in next word
	assign short_class = |hot_11[0:idx_ka2-1];	// AWT..JS
	assign byte_class  = hot_11[idx_ka2];
	assign io_class    = hot_01[idx_ou] | hot_01[idx_in];

endmodule

`default_nettype wire

// ==== rtl/p_d.sv ====
////////////////////////////////////////
// P-D instruction decode unit
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module p_d
	import p_d_pkg::*;
(
	input  wire           clk_sys,
	input  wire           rst_n,
	input  wire ir_word_t w,	// Internal W bus
	input  wire           strob1,	// Load strobe
	input  wire           w_ir,	// W bus to IR
	output ir_word_t      ir,
	output logic          c0,	// C field is zero
	output op_t           op,
	output logic          illegal,
	output logic          norm_arg,
	output logic          two_word,
	output logic          short_class,
	output logic          byte_class,
	output logic          io_class,
	output reg_id_t       reg_a,
	output reg_id_t       reg_b,
	output reg_id_t       reg_c,
	output logic          d,
	output ir_word_t      arg
);

	ir u_ir (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.w       (w),
		.strob1  (strob1),
		.w_ir    (w_ir),
		.ir      (ir)
	);

	assign c0 = ~|ir[13:15];	// Register r0 or next-word argument

	op_decode u_op_decode (
		.ir          (ir),
		.op          (op),
		.illegal     (illegal),
		.norm_arg    (norm_arg),
		.two_word    (two_word),
		.short_class (short_class),
		.byte_class  (byte_class),
		.io_class    (io_class)
	);

	// Class flags pick the argument form
	arg_extract u_arg_extract (
		.ir          (ir),
		.short_class (short_class),
		.byte_class  (byte_class),
		.reg_a       (reg_a),
		.reg_b       (reg_b),
		.reg_c       (reg_c),
		.d           (d),
		.arg         (arg)
	);

endmodule

`default_nettype wire

// ==== rtl/p_d_params.svh ====
////////////////////////////////////////
// P-D field widths
////////////////////////////////////////
`ifndef P_D_PARAMS_SVH
`define P_D_PARAMS_SVH

// Instruction word, same as the internal W bus
`define P_D_WORD_W 16

// Opcode field, bits 0..5 of the instruction
`define P_D_OP_W 6

// One register field, A, B or C
`define P_D_REG_W 3

`endif

// ==== rtl/p_d_pkg.sv ====
////////////////////////////////////////
// P-D shared types
////////////////////////////////////////
`default_nettype none

`include "p_d_params.svh"

package p_d_pkg;

	typedef logic [0:`P_D_WORD_W-1] ir_word_t;	// Bit 0 is the MSB, as on the schematics
	typedef logic [`P_D_REG_W-1:0] reg_id_t;	// Register number r0..r7

	// Each code equals the opcode itself, so a waveform shows {group, index}.
	// Group 00 has no instructions and collapses to op_ill
	typedef enum logic [`P_D_OP_W-1:0] {
		op_ill   = 6'h00,
		// Group 01, normal argument
		op_lw    = 6'h10, op_tw    = 6'h11, op_ls    = 6'h12, op_ri    = 6'h13,
		op_rw    = 6'h14, op_pw    = 6'h15, op_rj    = 6'h16, op_is    = 6'h17,
		op_bb    = 6'h18, op_bm    = 6'h19, op_bs    = 6'h1a, op_bc    = 6'h1b,
		op_bn    = 6'h1c, op_ou    = 6'h1d, op_in    = 6'h1e, op_pufa  = 6'h1f,
		// Group 10, normal argument
		op_aw    = 6'h20, op_ac    = 6'h21, op_sw    = 6'h22, op_cw    = 6'h23,
		op_or    = 6'h24, op_om    = 6'h25, op_nr    = 6'h26, op_nm    = 6'h27,
		op_er    = 6'h28, op_em    = 6'h29, op_xr    = 6'h2a, op_xm    = 6'h2b,
		op_cl    = 6'h2c, op_lb    = 6'h2d, op_rb    = 6'h2e, op_cb    = 6'h2f,
		// Group 11, short argument (0..8), byte argument (9), extended groups
		op_awt   = 6'h30, op_trb   = 6'h31, op_irb   = 6'h32, op_drb   = 6'h33,
		op_cwt   = 6'h34, op_lwt   = 6'h35, op_lws   = 6'h36, op_rws   = 6'h37,
		op_js    = 6'h38, op_ka2   = 6'h39, op_grp_c = 6'h3a, op_grp_s = 6'h3b,
		op_grp_j = 6'h3c, op_grp_l = 6'h3d, op_grp_g = 6'h3e, op_brc   = 6'h3f
	} op_t;

endpackage

`default_nettype wire

// ==== test/tb_p_d.sv ====
////////////////////////////////////////
// P-D decode unit testbench
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

`include "p_d_params.svh"

module tb_p_d
	import p_d_pkg::*;
();

	localparam int n_load  = 200;	// Gating test steps
	localparam int n_class = 200;	// Class flag test steps
	localparam int n_field = 200;	// Field test steps
	localparam int total_cycles = 10 + n_load + 64 + n_class + n_field + 8;

	// Mnemonic order per group, index 0 first
	localparam op_t tab_01 [16] = '{op_lw, op_tw, op_ls, op_ri, op_rw, op_pw, op_rj, op_is,
		op_bb, op_bm, op_bs, op_bc, op_bn, op_ou, op_in, op_pufa};
	localparam op_t tab_10 [16] = '{op_aw, op_ac, op_sw, op_cw, op_or, op_om, op_nr, op_nm,
		op_er, op_em, op_xr, op_xm, op_cl, op_lb, op_rb, op_cb};
	localparam op_t tab_11 [16] = '{op_awt, op_trb, op_irb, op_drb, op_cwt, op_lwt, op_lws,
		op_rws, op_js, op_ka2, op_grp_c, op_grp_s, op_grp_j, op_grp_l, op_grp_g, op_brc};

	logic     clk_sys;
	logic     rst_n;
	ir_word_t w;
	logic     strob1;
	logic     w_ir;
	ir_word_t ir;
	logic     c0, illegal, norm_arg, two_word, short_class, byte_class, io_class, d;
	op_t      op;
	reg_id_t  reg_a, reg_b, reg_c;
	ir_word_t arg;

	ir_word_t ref_ir;	// Model copy of IR
	int       pass_count = 0;
	int       fail_count = 0;

	p_d p_d_inst (
		.clk_sys (clk_sys), .rst_n (rst_n), .w (w), .strob1 (strob1), .w_ir (w_ir),
		.ir (ir), .c0 (c0), .op (op), .illegal (illegal), .norm_arg (norm_arg),
		.two_word (two_word), .short_class (short_class), .byte_class (byte_class),
		.io_class (io_class), .reg_a (reg_a), .reg_b (reg_b), .reg_c (reg_c),
		.d (d), .arg (arg)
	);

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;	// 8 ns period
	end

	// Ends a stuck run
	initial begin
		#(2 * total_cycles * 8);
		$display("Timeout: simulation did not finish within %0d cycles", 2 * total_cycles);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	task automatic check_word(input string name, input ir_word_t got, input ir_word_t exp);
		if (got !== exp) begin
			$display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
			fail_count++;
		end else pass_count++;
	endtask

	task automatic check_op(input op_t got, input op_t exp);
		if (got !== exp) begin
			$display("FAILED at %0t: op is %s, expected %s", $time, got.name(), exp.name());
			fail_count++;
		end else pass_count++;
	endtask

	task automatic check_reg(input string name, input reg_id_t got, input reg_id_t exp);
		if (got !== exp) begin
			$display("FAILED at %0t: %s is %0d, expected %0d", $time, name, got, exp);
			fail_count++;
		end else pass_count++;
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("FAILED at %0t: %s is %b, expected %b", $time, name, got, exp);
			fail_count++;
		end else pass_count++;
	endtask

	// Every output against the model at a falling edge
	task automatic check_outputs();
		logic [0:1] grp;
		logic [0:3] idx;
		logic       short_e, byte_e, norm_e, c0_e;
		op_t        op_e;
		ir_word_t   arg_e;
		grp = ref_ir[0:1];
		idx = ref_ir[2:5];
		c0_e = (ref_ir[13:15] == 3'd0);
		norm_e = (grp == 2'b01) || (grp == 2'b10);
		short_e = (grp == 2'b11) && (idx <= 4'd8);	// AWT through JS
		byte_e = (grp == 2'b11) && (idx == 4'd9);	// KA2
		case (grp)
			2'b01: op_e = tab_01[idx];
			2'b10: op_e = tab_10[idx];
			2'b11: op_e = tab_11[idx];
			default: op_e = op_ill;
		endcase
		arg_e = '0;
		if (short_e) begin
			arg_e = `P_D_WORD_W'(ref_ir[10:15]);	// Magnitude
			if (ref_ir[6]) arg_e = 16'd0 - arg_e;	// Negative when D is set
		end else if (byte_e) begin
			arg_e = `P_D_WORD_W'(ref_ir[8:15]);
		end
		check_word("ir", ir, ref_ir);
		check_op(op, op_e);
		check_bit("illegal", illegal, grp == 2'b00);
		check_bit("norm_arg", norm_arg, norm_e);
		check_bit("two_word", two_word, norm_e && c0_e);
		check_bit("short_class", short_class, short_e);
		check_bit("byte_class", byte_class, byte_e);
		check_bit("io_class", io_class, op_e == op_ou || op_e == op_in);
		check_bit("c0", c0, c0_e);
		check_reg("reg_a", reg_a, ref_ir[7:9]);
		check_reg("reg_b", reg_b, ref_ir[10:12]);
		check_reg("reg_c", reg_c, ref_ir[13:15]);
		check_bit("d", d, ref_ir[6]);
		check_word("arg", arg, arg_e);
	endtask

	// One cycle from falling edge to falling edge
	task automatic step(input ir_word_t w_val, input logic s, input logic wi);
		w = w_val;
		strob1 = s;
		w_ir = wi;
		@(posedge clk_sys);
		if (s && wi) ref_ir = w_val;	// Load rule
		@(negedge clk_sys);
		check_outputs();
	endtask

	task automatic report_test(input string name, input int fails_before);
		if (fail_count == fails_before) $display("%s: ok", name);
		else $display("%s: %0d checks failed", name, fail_count - fails_before);
	endtask

	initial begin
		int       start;
		ir_word_t rw;
		void'($urandom(32'h1af73223));
		rst_n = 1'b0;
		w = '0;
		strob1 = 1'b0;
		w_ir = 1'b0;
		ref_ir = '0;
		repeat (5) @(posedge clk_sys);
		@(negedge clk_sys);
		rst_n = 1'b1;

		start = fail_count;
		check_outputs();
		check_op(op, op_ill);	// Directed reset values
		check_bit("illegal", illegal, 1'b1);
		check_bit("c0", c0, 1'b1);
		check_word("arg", arg, '0);
		report_test("reset state", start);

		start = fail_count;
		for (int k = 0; k < n_load; k++) begin
			step(ir_word_t'($urandom), 1'($urandom), 1'($urandom));
		end
		report_test("load gating", start);

		start = fail_count;
		for (int k = 0; k < 64; k++) begin
			rw = ir_word_t'($urandom);
			rw[0:5] = 6'(k);	// Opcode under test
			step(rw, 1'b1, 1'b1);
		end
		report_test("opcode sweep", start);

		start = fail_count;
		for (int k = 0; k < n_class; k++) begin
			rw = ir_word_t'($urandom);
			if (k % 4 == 0) rw[13:15] = 3'd0;	// More C=0 cases
			step(rw, 1'b1, 1'b1);
		end
		report_test("class flags", start);

		start = fail_count;
		step(16'b11_0000_1_000_000000, 1'b1, 1'b1);	// AWT, D set, magnitude zero
		step(16'b11_0000_1_000_111111, 1'b1, 1'b1);	// AWT, -63
		step(16'b11_1001_0_0_11111111, 1'b1, 1'b1);	// KA2, byte 255
		step(16'b11_1000_0_000_111111, 1'b1, 1'b1);	// JS, +63
		for (int k = 0; k < n_field; k++) begin
			rw = ir_word_t'($urandom);
			if (k % 2 == 0) rw[0:1] = 2'b11;	// Favor argument forms
			step(rw, 1'b1, 1'b1);
		end
		report_test("fields and arguments", start);

		$display("Checks: %0d passed, %0d failed", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire
